// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_frontend_top
FILELIST   := compile.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
+incdir+tests
rtl/fetch_pkg.sv
rtl/fetch_pc_gen.sv
rtl/branch_predecode.sv
rtl/inst_buffer.sv
rtl/frontend_top.sv
tests/tb_frontend_top.sv

// File: rtl/branch_predecode.sv
`timescale 1ns/1ps

module branch_predecode
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        flush_i,
    input  logic        resp_valid_i,
    input  logic [31:0] resp_pc_i,
    input  logic [31:0] resp_inst_i,
    output logic        redirect_valid_o,
    output logic [31:0] redirect_pc_o,
    output logic        pd_valid_o,
    output logic [31:0] pd_inst_o,
    output logic [31:0] pd_pc_o,
    output logic        pd_is_branch_o,
    output logic        pd_taken_o,
    output logic [31:0] pd_target_o
);

    inst_word_u  word;
    logic        drop_q;
    logic        live;
    logic        is_branch;
    logic        taken;
    logic [31:0] target;

    assign word.raw = resp_inst_i;

    // Response to a request made in the flush cycle is stale
    assign live = resp_valid_i && !drop_q;

    assign is_branch = word.branch_fmt.opcode == BRANCH_OPCODE;

    // Word offset scaled to bytes
    assign target = resp_pc_i
                  + {{14{word.branch_fmt.offset[15]}}, word.branch_fmt.offset, 2'b00};

    // Backward taken, forward not taken
    assign taken = is_branch && word.branch_fmt.offset[15];

    assign redirect_valid_o = live && taken;
    assign redirect_pc_o    = target;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            drop_q     <= 1'b0;
            pd_valid_o <= 1'b0;
        end else begin
            drop_q     <= flush_i;
            pd_valid_o <= live && !flush_i;
        end
    end

    // Payload, only looked at when pd_valid_o is set
    always_ff @(posedge clk) begin
        pd_inst_o      <= word.raw;
        pd_pc_o        <= resp_pc_i;
        pd_is_branch_o <= is_branch;
        pd_taken_o     <= taken;
        pd_target_o    <= target;
    end

    // Responses come back word aligned, so targets stay aligned too
    a_resp_aligned: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        resp_valid_i |-> resp_pc_i[1:0] == 2'b00
    );

endmodule

// File: rtl/fetch_pc_gen.sv
`timescale 1ns/1ps

module fetch_pc_gen
    import fetch_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    input  logic [31:0]             flush_pc_i,
    input  logic                    redirect_valid_i,
    input  logic [31:0]             redirect_pc_i,
    input  logic [IBUF_COUNT_W-1:0] free_count_i,
    output logic                    fetch_req_o,
    output logic [31:0]             fetch_pc_o
);

    // Held low for the first cycle out of reset
    logic        run_q;
    // Flush address waiting to be requested
    logic        restart_q;
    // Address of the next sequential request, or the restart address
    logic [31:0] pc_q;
    logic        has_room;

    // Room for the response in flight, the entry being written and this request
    assign has_room = free_count_i >= IBUF_COUNT_W'(3);

    assign fetch_req_o = run_q && has_room;

    // A pending restart outranks a predicted-taken redirect
    assign fetch_pc_o = (redirect_valid_i && !restart_q) ? redirect_pc_i : pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            run_q     <= 1'b0;
            restart_q <= 1'b0;
            pc_q      <= RESET_PC;
        end else begin
            run_q <= 1'b1;
            if (flush_i) begin
                restart_q <= 1'b1;
                pc_q      <= flush_pc_i;
            end else if (fetch_req_o) begin
                restart_q <= 1'b0;
                pc_q      <= fetch_pc_o + 32'd4;
            end else if (redirect_valid_i && !restart_q) begin
                // Throttled this cycle, so keep the target for later
                pc_q <= redirect_pc_i;
            end
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // First request after a flush goes to the flush address
    a_restart_pc: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $past(flush_i) && fetch_req_o |-> fetch_pc_o == $past(flush_pc_i)
    );

endmodule

// File: rtl/fetch_pkg.sv
package fetch_pkg;

    //////////////////////////////
    // Fetch and buffer constants
    //////////////////////////////

    // First fetch address out of reset
    localparam logic [31:0] RESET_PC = 32'h1c000000;

    // Instruction buffer geometry
    localparam int IBUF_DEPTH   = 16;
    localparam int IBUF_AW      = 4;
    // One bit wider than the pointers so that full is countable
    localparam int IBUF_COUNT_W = 5;

    // Major opcode of a PC-relative branch
    localparam logic [5:0] BRANCH_OPCODE = 6'b010011;

    //////////////////////////////
    // Instruction word
    //////////////////////////////

    // Same 32 bits, read either as a branch or as an opaque word
    typedef union packed {
        struct packed {
            logic [5:0]         opcode;
            // Word offset, relative to the branch address
            logic signed [15:0] offset;
            logic [9:0]         rest;
        } branch_fmt;
        logic [31:0] raw;
    } inst_word_u;

endpackage

// File: rtl/frontend_top.sv
`timescale 1ns/1ps

module frontend_top
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    // Instruction cache
    output logic        fetch_req_o,
    output logic [31:0] fetch_pc_o,
    input  logic        resp_valid_i,
    input  logic [31:0] resp_pc_i,
    input  logic [31:0] resp_inst_i,
    // Decode
    input  logic [1:0]  issue_en_i,
    input  logic        flush_i,
    input  logic [31:0] flush_pc_i,
    output logic        slot0_valid_o,
    output logic [31:0] slot0_inst_o,
    output logic [31:0] slot0_pc_o,
    output logic        slot0_is_branch_o,
    output logic        slot0_taken_o,
    output logic [31:0] slot0_target_o,
    output logic        slot1_valid_o,
    output logic [31:0] slot1_inst_o,
    output logic [31:0] slot1_pc_o,
    output logic        slot1_is_branch_o,
    output logic        slot1_taken_o,
    output logic [31:0] slot1_target_o
);

    logic                    pd_valid;
    logic [31:0]             pd_inst;
    logic [31:0]             pd_pc;
    logic                    pd_is_branch;
    logic                    pd_taken;
    logic [31:0]             pd_target;
    logic                    redirect_valid;
    logic [31:0]             redirect_pc;
    logic [IBUF_COUNT_W-1:0] free_count;

    fetch_pc_gen pc_gen_i (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .flush_pc_i       (flush_pc_i),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .free_count_i     (free_count),
        .fetch_req_o      (fetch_req_o),
        .fetch_pc_o       (fetch_pc_o)
    );

    branch_predecode predecode_i (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .resp_valid_i     (resp_valid_i),
        .resp_pc_i        (resp_pc_i),
        .resp_inst_i      (resp_inst_i),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc),
        .pd_valid_o       (pd_valid),
        .pd_inst_o        (pd_inst),
        .pd_pc_o          (pd_pc),
        .pd_is_branch_o   (pd_is_branch),
        .pd_taken_o       (pd_taken),
        .pd_target_o      (pd_target)
    );

    inst_buffer ibuf_i (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .flush_i           (flush_i),
        .pd_valid_i        (pd_valid),
        .pd_inst_i         (pd_inst),
        .pd_pc_i           (pd_pc),
        .pd_is_branch_i    (pd_is_branch),
        .pd_taken_i        (pd_taken),
        .pd_target_i       (pd_target),
        .issue_en_i        (issue_en_i),
        .free_count_o      (free_count),
        .slot0_valid_o     (slot0_valid_o),
        .slot0_inst_o      (slot0_inst_o),
        .slot0_pc_o        (slot0_pc_o),
        .slot0_is_branch_o (slot0_is_branch_o),
        .slot0_taken_o     (slot0_taken_o),
        .slot0_target_o    (slot0_target_o),
        .slot1_valid_o     (slot1_valid_o),
        .slot1_inst_o      (slot1_inst_o),
        .slot1_pc_o        (slot1_pc_o),
        .slot1_is_branch_o (slot1_is_branch_o),
        .slot1_taken_o     (slot1_taken_o),
        .slot1_target_o    (slot1_target_o)
    );

endmodule

// File: rtl/inst_buffer.sv
`timescale 1ns/1ps

module inst_buffer
    import fetch_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    input  logic                    pd_valid_i,
    input  logic [31:0]             pd_inst_i,
    input  logic [31:0]             pd_pc_i,
    input  logic                    pd_is_branch_i,
    input  logic                    pd_taken_i,
    input  logic [31:0]             pd_target_i,
    input  logic [1:0]              issue_en_i,
    output logic [IBUF_COUNT_W-1:0] free_count_o,
    output logic                    slot0_valid_o,
    output logic [31:0]             slot0_inst_o,
    output logic [31:0]             slot0_pc_o,
    output logic                    slot0_is_branch_o,
    output logic                    slot0_taken_o,
    output logic [31:0]             slot0_target_o,
    output logic                    slot1_valid_o,
    output logic [31:0]             slot1_inst_o,
    output logic [31:0]             slot1_pc_o,
    output logic                    slot1_is_branch_o,
    output logic                    slot1_taken_o,
    output logic [31:0]             slot1_target_o
);

    //////////////////////////////
    // Storage
    //////////////////////////////

    logic [31:0] inst_mem   [IBUF_DEPTH];
    logic [31:0] pc_mem     [IBUF_DEPTH];
    logic        branch_mem [IBUF_DEPTH];
    logic        taken_mem  [IBUF_DEPTH];
    logic [31:0] target_mem [IBUF_DEPTH];

    logic [IBUF_AW-1:0]      head_q;
    logic [IBUF_AW-1:0]      tail_q;
    logic [IBUF_AW-1:0]      head_nx;
    logic [IBUF_COUNT_W-1:0] count_q;
    logic [IBUF_COUNT_W-1:0] pop_req;
    logic [IBUF_COUNT_W-1:0] pop_cnt;
    logic                    push;
    logic                    take0;
    logic                    take1;

    assign free_count_o = IBUF_COUNT_W'(IBUF_DEPTH) - count_q;

    // Entry written during a flush belongs to the old path
    assign push = pd_valid_i && !flush_i;

    // Slot 1 counts only together with slot 0
    always_comb begin
        if (issue_en_i[0] && issue_en_i[1]) begin
            pop_req = IBUF_COUNT_W'(2);
        end else if (issue_en_i[0]) begin
            pop_req = IBUF_COUNT_W'(1);
        end else begin
            pop_req = '0;
        end
    end

    // Never pop more than is stored
    assign pop_cnt = (pop_req > count_q) ? count_q : pop_req;
    assign take0   = pop_cnt != '0;
    assign take1   = pop_cnt == IBUF_COUNT_W'(2);

    // Wraps around at the end of the array
    assign head_nx = head_q + 1'b1;

    //////////////////////////////
    // Pointers and occupancy
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                tail_q <= tail_q + 1'b1;
            end
            head_q  <= head_q + IBUF_AW'(pop_cnt);
            count_q <= count_q + IBUF_COUNT_W'(push) - pop_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            inst_mem[tail_q]   <= pd_inst_i;
            pc_mem[tail_q]     <= pd_pc_i;
            branch_mem[tail_q] <= pd_is_branch_i;
            taken_mem[tail_q]  <= pd_taken_i;
            target_mem[tail_q] <= pd_target_i;
        end
    end

    //////////////////////////////
    // Issue slots
    //////////////////////////////

    // Oldest entry to slot 0, the next one to slot 1
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            slot0_valid_o     <= 1'b0;
            slot0_inst_o      <= '0;
            slot0_pc_o        <= '0;
            slot0_is_branch_o <= 1'b0;
            slot0_taken_o     <= 1'b0;
            slot0_target_o    <= '0;
            slot1_valid_o     <= 1'b0;
            slot1_inst_o      <= '0;
            slot1_pc_o        <= '0;
            slot1_is_branch_o <= 1'b0;
            slot1_taken_o     <= 1'b0;
            slot1_target_o    <= '0;
        end else begin
            slot0_valid_o     <= take0;
            slot0_inst_o      <= take0 ? inst_mem[head_q] : '0;
            slot0_pc_o        <= take0 ? pc_mem[head_q] : '0;
            slot0_is_branch_o <= take0 && branch_mem[head_q];
            slot0_taken_o     <= take0 && taken_mem[head_q];
            slot0_target_o    <= take0 ? target_mem[head_q] : '0;
            slot1_valid_o     <= take1;
            slot1_inst_o      <= take1 ? inst_mem[head_nx] : '0;
            slot1_pc_o        <= take1 ? pc_mem[head_nx] : '0;
            slot1_is_branch_o <= take1 && branch_mem[head_nx];
            slot1_taken_o     <= take1 && taken_mem[head_nx];
            slot1_target_o    <= take1 ? target_mem[head_nx] : '0;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Fetch throttling upstream must keep a full buffer from being written
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        pd_valid_i |-> count_q != IBUF_COUNT_W'(IBUF_DEPTH)
    );

    // Counter and pointers describe the same occupancy
    a_count_matches_ptrs: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        count_q <= IBUF_COUNT_W'(IBUF_DEPTH) && count_q[IBUF_AW-1:0] == tail_q - head_q
    );

endmodule

// File: tests/fetch_model.svh
`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

// Every address bit feeds every result bit
function automatic logic [31:0] addr_hash(input logic [31:0] addr);
    logic [31:0] x;
    x = addr ^ (addr >> 15);
    x = x * 32'h2c1b3c6d;
    x = x ^ (x >> 12);
    x = x * 32'h297a2d39;
    x = x ^ (x >> 15);
    return x;
endfunction

// Cache contents, about one word in eight is a branch
function automatic logic [31:0] mem_word(input logic [31:0] pc);
    logic [31:0] h;
    logic [31:0] w;
    logic [15:0] offset;
    h = addr_hash(pc);
    w = addr_hash(~pc);
    // Straight-line code for the first 16 words after reset
    if (h[2:0] != 3'd0 || (pc - RESET_PC) < 32'd64) begin
        if (w[31:26] == BRANCH_OPCODE) begin
            w[31] = ~w[31];
        end
        return w;
    end
    if (h[5:3] < 3'd3) begin
        // Backward, mostly short loops
        if (h[8:6] != 3'd0) begin
            offset = -(16'd1 + 16'(h[12:9]));
        end else begin
            offset = -(16'd1 + 16'(h[22:13]));
        end
    end else begin
        offset = 16'(h[20:9]);
    end
    return {BRANCH_OPCODE, offset, w[9:0]};
endfunction

function automatic logic branch_word(input logic [31:0] w);
    return w[31:26] == BRANCH_OPCODE;
endfunction

// Backward taken, forward not taken
function automatic logic predict_taken(input logic [31:0] w);
    return branch_word(w) && w[25];
endfunction

// Four bytes per word of signed offset
function automatic logic [31:0] branch_target(input logic [31:0] pc, input logic [31:0] w);
    return pc + 32'($signed(w[25:10])) * 32'd4;
endfunction

// Next address of the expected instruction stream
function automatic logic [31:0] next_pc(input logic [31:0] pc);
    logic [31:0] w;
    w = mem_word(pc);
    return predict_taken(w) ? branch_target(pc, w) : pc + 32'd4;
endfunction

`endif

// File: tests/tb_frontend_top.sv
`timescale 1ns/1ps

module tb_frontend_top
    import fetch_pkg::*;
();

    localparam logic [31:0] SEED = 32'hc02f28e2;

    logic        clk;
    logic        rst_n;
    logic        rst_next;
    logic        fetch_req;
    logic [31:0] fetch_pc;
    logic        resp_valid;
    logic [31:0] resp_pc;
    logic [31:0] resp_inst;
    logic [1:0]  issue_en;
    logic        flush;
    logic [31:0] flush_pc;
    logic        slot_valid [2];
    logic [31:0] slot_inst  [2];
    logic [31:0] slot_pc    [2];
    logic        slot_br    [2];
    logic        slot_tk    [2];
    logic [31:0] slot_tgt   [2];

    // Scoreboard state
    int          errors;
    int          checks;
    int          tests_ok;
    int          issued;
    int          taken_seen;
    int          duals;
    logic [31:0] exp_pc;
    logic        req_q;
    logic [31:0] req_pc_q;
    logic [1:0]  issue_q;
    logic        flush_q;

    `include "fetch_model.svh"

    frontend_top dut_i (
        .clk               (clk),
        .rst_n_i           (rst_n),
        .fetch_req_o       (fetch_req),
        .fetch_pc_o        (fetch_pc),
        .resp_valid_i      (resp_valid),
        .resp_pc_i         (resp_pc),
        .resp_inst_i       (resp_inst),
        .issue_en_i        (issue_en),
        .flush_i           (flush),
        .flush_pc_i        (flush_pc),
        .slot0_valid_o     (slot_valid[0]),
        .slot0_inst_o      (slot_inst[0]),
        .slot0_pc_o        (slot_pc[0]),
        .slot0_is_branch_o (slot_br[0]),
        .slot0_taken_o     (slot_tk[0]),
        .slot0_target_o    (slot_tgt[0]),
        .slot1_valid_o     (slot_valid[1]),
        .slot1_inst_o      (slot_inst[1]),
        .slot1_pc_o        (slot_pc[1]),
        .slot1_is_branch_o (slot_br[1]),
        .slot1_taken_o     (slot_tk[1]),
        .slot1_target_o    (slot_tgt[1])
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////
    // Checking helpers
    //////////////////////////////

    task automatic report_error(input string msg);
        errors++;
        $display("[FAIL] %0t ns: %s", $time, msg);
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout at %0t ns while waiting for %s", $time, what);
    endtask

    function automatic logic [1:0] random_strobes();
        return 2'($urandom_range(3));
    endfunction

    // Slots hold the result of the strobes driven one cycle earlier
    task automatic check_slots();
        logic [31:0] w;
        if (slot_valid[1] && !slot_valid[0])
            report_error("slot 1 valid without slot 0");
        if (flush_q && (slot_valid[0] || slot_valid[1]))
            report_error("slot valid in the cycle after a flush");
        if ((!issue_q[0] && slot_valid[0]) || (issue_q != 2'b11 && slot_valid[1]))
            report_error("more slots valid than strobes asserted");
        if (slot_valid[0] && slot_valid[1])
            duals++;
        for (int k = 0; k < 2; k++) begin
            if (!slot_valid[k]) begin
                if ({slot_inst[k], slot_pc[k], slot_br[k], slot_tk[k], slot_tgt[k]} !== '0)
                    report_error($sformatf("unused slot %0d has nonzero fields", k));
            end else begin
                w = mem_word(exp_pc);
                checks++;
                if (slot_pc[k] !== exp_pc || slot_inst[k] !== w
                        || slot_br[k] !== branch_word(w) || slot_tk[k] !== predict_taken(w)
                        || (branch_word(w) && slot_tgt[k] !== branch_target(exp_pc, w)))
                    report_error($sformatf(
                        "slot %0d got pc %h inst %h br %b tk %b tgt %h, expected pc %h inst %h",
                        k, slot_pc[k], slot_inst[k], slot_br[k], slot_tk[k], slot_tgt[k],
                        exp_pc, w));
                issued++;
                if (predict_taken(w))
                    taken_seen++;
                exp_pc = next_pc(exp_pc);
            end
        end
    endtask

    // One clock cycle: check, answer the cache request, drive decode and flush
    task automatic step_cycle(input logic [1:0] en, input logic do_flush,
                              input logic [31:0] fpc);
        @(negedge clk);
        check_slots();
        rst_n      = rst_next;
        resp_valid = req_q;
        resp_pc    = req_q ? req_pc_q : '0;
        resp_inst  = req_q ? mem_word(req_pc_q) : '0;
        issue_en   = en;
        flush      = do_flush;
        flush_pc   = fpc;
        issue_q    = en;
        flush_q    = do_flush;
        if (do_flush)
            exp_pc = fpc;
        // Request address settles through the redirect path
        #1;
        req_q    = fetch_req;
        req_pc_q = fetch_pc;
        if (!rst_n && fetch_req !== 1'b0)
            report_error("fetch request during reset");
    endtask

    task automatic finish_test(input int num, input string name, input int start);
        if (errors == start) begin
            tests_ok++;
            $display("test %0d, %s: ok", num, name);
        end else begin
            $display("test %0d, %s: %0d errors", num, name, errors - start);
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        int          start;
        int          base;
        int          n;
        logic [31:0] fpc;
        void'($urandom(SEED));
        rst_n      = 1'b0;
        rst_next   = 1'b0;
        resp_valid = 1'b0;
        resp_pc    = '0;
        resp_inst  = '0;
        issue_en   = 2'b00;
        flush      = 1'b0;
        flush_pc   = '0;
        errors     = 0;
        checks     = 0;
        tests_ok   = 0;
        issued     = 0;
        taken_seen = 0;
        duals      = 0;
        exp_pc     = RESET_PC;
        req_q      = 1'b0;
        req_pc_q   = '0;
        issue_q    = 2'b00;
        flush_q    = 1'b0;
        repeat (15)
            step_cycle(2'b00, 1'b0, '0);
        rst_next = 1'b1;

        start = errors;
        base  = issued;
        for (n = 0; n < 100 && issued - base < 12; n++)
            step_cycle(2'b01, 1'b0, '0);
        if (issued - base < 12)
            report_timeout("twelve single issues after reset");
        finish_test(1, "reset and single issue", start);

        start = errors;
        base  = taken_seen;
        for (n = 0; n < 3000 && taken_seen - base < 6; n++)
            step_cycle(random_strobes(), 1'b0, '0);
        if (taken_seen - base < 6)
            report_timeout("six predicted-taken branches to issue");
        finish_test(2, "branch predecode and redirect", start);

        start = errors;
        base  = issued;
        repeat (400)
            step_cycle(random_strobes(), 1'b0, '0);
        if (issued - base < 200)
            report_error($sformatf("only %0d issued in 400 random cycles", issued - base));
        finish_test(3, "random dual issue", start);

        start = errors;
        repeat (40)
            step_cycle(2'b00, 1'b0, '0);
        if (req_q)
            report_error("fetch still requesting with a full buffer");
        base = duals;
        repeat (8)
            step_cycle(2'b11, 1'b0, '0);
        if (duals - base < 7)
            report_error("full buffer did not drain at two per cycle");
        repeat (30)
            step_cycle(2'b11, 1'b0, '0);
        finish_test(4, "fill and drain", start);

        start = errors;
        repeat (8) begin
            repeat ($urandom_range(30, 1))
                step_cycle(random_strobes(), 1'b0, '0);
            fpc = $urandom() & 32'hffff_fffc;
            step_cycle(random_strobes(), 1'b1, fpc);
            base = issued;
            for (n = 0; n < 40 && issued == base; n++)
                step_cycle(2'b01, 1'b0, '0);
            if (issued == base)
                report_timeout("the first instruction after a flush");
        end
        finish_test(5, "flush and restart", start);

        $display("%0d slot checks, %0d errors, %0d of 5 tests clean", checks, errors, tests_ok);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
